/* source/serial_rx_cfg.svh */
`ifndef SERIAL_RX_CFG_SVH
`define SERIAL_RX_CFG_SVH

// clk cycles per half period of sclk
`define BIT_CLK_DIV 4

// number of bytes the receive fifo holds
// the pointers wrap on their own so this has to be a power of two
`define FIFO_DEPTH 8

// first byte of every frame sent by the host
`define SYNC_BYTE 8'hA5

`endif

/* source/serial_rx_pkg.sv */
package serial_rx_pkg;

   // payload widths on the link
   typedef logic [7:0] byte_t;      // one byte as it comes off the serial line
   typedef logic [7:0] reg_addr_t;  // register address field of a frame

   // position inside a frame that the parser expects next
   typedef enum logic [1:0] {
      ST_HUNT = 2'd0,  // dropping bytes until the sync byte shows up
      ST_ADDR = 2'd1,  // next byte is the register address
      ST_DATA = 2'd2,  // next byte is the write data
      ST_CSUM = 2'd3   // next byte is the checksum over address and data
   } parse_state_t;

   // check byte that the host appends to every frame
   function automatic byte_t frame_checksum(input reg_addr_t addr, input byte_t data);
      return byte_t'(addr) ^ data;  // plain xor of the two payload bytes
   endfunction

endpackage

/* source/spi_byte_deserializer.sv */
`timescale 1ns/1ps
`include "serial_rx_cfg.svh"

module spi_byte_deserializer (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 serial_in,   // host data, msb first
   output logic                 sclk,        // bit clock handed to the host
   output serial_rx_pkg::byte_t byte_data,   // last complete byte
   output logic                 byte_valid   // one cycle strobe per finished byte
);
   import serial_rx_pkg::*;

   localparam int DIV_W = $clog2(`BIT_CLK_DIV);  // width of the half period counter

   logic [DIV_W-1:0] div_cnt;     // clk cycles spent in the current sclk phase
   logic             sclk_q;      // sclk delayed by one clk for edge detection
   logic             sclk_fall;   // high in the cycle right after sclk drops
   logic [2:0]       bit_cnt;     // bits already shifted into the current byte
   logic             byte_done;   // the eighth bit of a byte is sampled in this cycle
   byte_t            shift_q;     // bits of the byte under assembly
   byte_t            shift_next;  // shift register including this cycle's sample

   // sclk generation, the host shifts out on rising and we sample on falling
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         div_cnt <= '0;           // start a fresh half period
         sclk    <= 1'b0;         // sclk idles low out of reset
      end else if (div_cnt == DIV_W'(`BIT_CLK_DIV - 1)) begin
         div_cnt <= '0;           // half period is over
         sclk    <= ~sclk;        // flip the bit clock
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sclk_q <= 1'b0;          // matches the idle level so no false edge
      end else begin
         sclk_q <= sclk;          // previous sclk level
      end
   end

   assign sclk_fall  = sclk_q & ~sclk;                 // sclk was high and is now low
   assign byte_done  = sclk_fall && (bit_cnt == 3'd7);  // counter is about to wrap
   assign shift_next = {shift_q[6:0], serial_in};       // msb first so new bits enter at the bottom

   // bit position and the byte strobe
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bit_cnt    <= '0;        // first sample after reset is bit 7 of a byte
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= byte_done; // strobe lines up with the new byte_data
         if (sclk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;  // wraps from 7 back to 0 by itself
         end
      end
   end

   // the finished byte goes out on the same edge that takes its last bit
   // so a burst that stops after a byte still delivers that byte
   always_ff @(posedge clk) begin
      if (sclk_fall) begin
         shift_q <= shift_next;   // take serial_in into the low bit
      end
      if (byte_done) begin
         byte_data <= shift_next; // publish the full eight bits
      end
   end

endmodule

/* source/byte_fifo.sv */
`timescale 1ns/1ps
`include "serial_rx_cfg.svh"

module byte_fifo (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wr_en,     // byte strobe from the deserializer
   input  serial_rx_pkg::byte_t wr_data,   // byte to store
   input  logic                 pop,       // remove the head at the next edge
   output serial_rx_pkg::byte_t rd_data,   // head of the fifo, valid while empty is low
   output logic                 empty,     // no byte stored
   output logic                 overflow   // a byte was dropped since reset
);
   import serial_rx_pkg::*;

   localparam int DEPTH = `FIFO_DEPTH;     // entries in the ring
   localparam int AW    = $clog2(DEPTH);   // pointer width
   localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);  // occupancy when every slot is taken

   byte_t         mem [DEPTH];   // byte storage
   logic [AW-1:0] wr_ptr;        // next slot to write
   logic [AW-1:0] rd_ptr;        // slot of the current head
   logic [AW:0]   count;         // bytes currently stored
   logic          full;          // every slot holds a byte
   logic          do_rd;         // a pop that really removes a byte
   logic          do_wr;         // a write that really stores a byte

   assign full    = (count == FULL_COUNT);
   assign empty   = (count == '0);
   assign do_rd   = pop && !empty;               // popping an empty fifo does nothing
   assign do_wr   = wr_en && (!full || do_rd);   // when full a pop in the same cycle frees the slot
   assign rd_data = mem[rd_ptr];                 // show ahead read of the head

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps since the depth is a power of two
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;  // write only
            2'b01:   count <= count - 1'b1;  // pop only
            default: count <= count;         // both or neither leave the level alone
         endcase
         if (wr_en && !do_wr) begin
            overflow <= 1'b1;          // the byte is lost and the flag sticks until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;       // seen at rd_data one cycle later if it is the head
      end
   end

endmodule

/* source/frame_parser.sv */
`timescale 1ns/1ps
`include "serial_rx_cfg.svh"

module frame_parser (
   input  logic                     clk,
   input  logic                     rst,
   input  serial_rx_pkg::byte_t     rd_data,      // head of the receive fifo
   input  logic                     empty,        // fifo has nothing to offer
   input  logic                     hold,         // downstream is not ready for writes
   output logic                     pop,          // take the head this cycle
   output logic                     wr_valid,     // one cycle register write strobe
   output serial_rx_pkg::reg_addr_t wr_addr,      // address of the write
   output serial_rx_pkg::byte_t     wr_data,      // data of the write
   output logic                     frame_error   // one cycle strobe for a bad checksum
);
   import serial_rx_pkg::*;

   parse_state_t state;          // which frame byte is expected
   parse_state_t state_n;        // state after this cycle
   reg_addr_t    addr_q;         // address byte of the frame in progress
   byte_t        data_q;         // data byte of the frame in progress
   logic         csum_ok;        // head matches the checksum of the stored bytes
   logic         wr_valid_n;     // write strobe for the next cycle
   logic         frame_error_n;  // error strobe for the next cycle

   // one byte per cycle as long as there is one and the sink is not holding us off
   assign pop = !empty && !hold;

   assign csum_ok = (rd_data == frame_checksum(addr_q, data_q));

   always_comb begin
      state_n       = state;
      wr_valid_n    = 1'b0;
      frame_error_n = 1'b0;
      if (pop) begin                 // the state only moves when a byte is consumed
         case (state)
            ST_HUNT: begin
               if (rd_data == `SYNC_BYTE) begin
                  state_n = ST_ADDR;  // anything else before a frame is dropped
               end
            end
            ST_ADDR: begin
               state_n = ST_DATA;     // address is captured below
            end
            ST_DATA: begin
               state_n = ST_CSUM;     // data is captured below
            end
            ST_CSUM: begin
               wr_valid_n    = csum_ok;   // good frame becomes a register write
               frame_error_n = !csum_ok;  // bad frame is reported and thrown away
               state_n       = ST_HUNT;   // look for the next sync either way
            end
            default: begin
               state_n = ST_HUNT;
            end
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= ST_HUNT;
         wr_valid    <= 1'b0;
         frame_error <= 1'b0;
      end else begin
         state       <= state_n;
         wr_valid    <= wr_valid_n;      // pulses one cycle after the checksum pop
         frame_error <= frame_error_n;
      end
   end

   // frame payload, held until the next frame overwrites it
   // a new address can only arrive two pops after the checksum so the strobe sees stable values
   always_ff @(posedge clk) begin
      if (pop && state == ST_ADDR) begin
         addr_q <= rd_data;
      end
      if (pop && state == ST_DATA) begin
         data_q <= rd_data;
      end
   end

   assign wr_addr = addr_q;   // qualified by wr_valid
   assign wr_data = data_q;

endmodule

/* source/serial_rx_top.sv */
`timescale 1ns/1ps

module serial_rx_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     serial_in,    // data line from the host
   input  logic                     hold,         // back pressure from the register file
   output logic                     sclk,         // bit clock to the host
   output logic                     wr_valid,     // register write strobe
   output serial_rx_pkg::reg_addr_t wr_addr,      // register write address
   output serial_rx_pkg::byte_t     wr_data,      // register write data
   output logic                     frame_error,  // checksum mismatch strobe
   output logic                     overflow      // receive fifo lost a byte
);
   import serial_rx_pkg::*;

   byte_t rx_byte;      // byte assembled by the deserializer
   logic  rx_valid;     // strobe that writes rx_byte into the fifo
   byte_t head_byte;    // oldest byte waiting in the fifo
   logic  fifo_empty;   // nothing for the parser to take
   logic  fifo_pop;     // parser consumes the head

   // serial line to bytes
   spi_byte_deserializer u_deser (
      .clk        (clk),
      .rst        (rst),
      .serial_in  (serial_in),
      .sclk       (sclk),
      .byte_data  (rx_byte),
      .byte_valid (rx_valid)
   );

   // absorbs bursts while the register file holds off
   byte_fifo u_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_en    (rx_valid),
      .wr_data  (rx_byte),
      .pop      (fifo_pop),
      .rd_data  (head_byte),
      .empty    (fifo_empty),
      .overflow (overflow)
   );

   // bytes to register writes
   frame_parser u_parser (
      .clk         (clk),
      .rst         (rst),
      .rd_data     (head_byte),
      .empty       (fifo_empty),
      .hold        (hold),
      .pop         (fifo_pop),
      .wr_valid    (wr_valid),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .frame_error (frame_error)
   );

endmodule

/* test/serial_rx_assert.sv */
`timescale 1ns/1ps

module serial_rx_assert (
   input logic clk,
   input logic rst,
   input logic pop,          // parser takes the fifo head
   input logic empty,        // fifo holds no byte
   input logic overflow,     // sticky fifo overflow flag
   input logic wr_valid,     // register write strobe
   input logic frame_error   // checksum error strobe
);

   int fail_count = 0;  // number of failed checks so far

   // the parser only pops when the fifo offers a byte
   pop_needs_data: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
      else begin
         $error("pop issued while the fifo is empty");
         fail_count++;
      end

   // once a byte is lost the flag stays up until reset
   overflow_sticks: assert property (@(posedge clk) disable iff (rst) overflow |=> overflow)
      else begin
         $error("overflow fell without a reset");
         fail_count++;
      end

   // a frame ends either as a write or as an error, never both
   one_outcome: assert property (@(posedge clk) disable iff (rst) !(wr_valid && frame_error))
      else begin
         $error("wr_valid and frame_error are high in the same cycle");
         fail_count++;
      end

endmodule

bind byte_fifo serial_rx_assert u_fifo_chk (
   .clk(clk), .rst(rst), .pop(pop), .empty(empty), .overflow(overflow),
   .wr_valid(1'b0), .frame_error(1'b0)
);

bind frame_parser serial_rx_assert u_parser_chk (
   .clk(clk), .rst(rst), .pop(pop), .empty(empty), .overflow(1'b0),
   .wr_valid(wr_valid), .frame_error(frame_error)
);

/* test/serial_rx_tb.sv */
`timescale 1ns/1ps
`include "serial_rx_cfg.svh"

module serial_rx_tb;
   import serial_rx_pkg::*;

   localparam int CLK_HALF     = 20;                            // 40 ns clock period
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int VEC_WORDS    = 256;                           // room for the whole vectors file
   localparam int DRAIN_CYCLES = 4 * `BIT_CLK_DIV + `FIFO_DEPTH + 4;  // last bit in, fifo empty

   logic      clk = 1'b0;
   logic      rst;
   logic      serial_in;
   logic      hold;
   logic      sclk;
   logic      wr_valid;
   reg_addr_t wr_addr;
   byte_t     wr_data;
   logic      frame_error;
   logic      overflow;

   logic [15:0] vec_mem [VEC_WORDS];  // raw words of the vectors file

   byte_t     tx_queue[$];            // bytes of the current case not yet started
   byte_t     tx_byte = 8'h00;        // byte on the wire right now
   logic      tx_live = 1'b0;         // the byte on the wire belongs to a case
   logic      sclk_seen = 1'b0;       // sclk level at the previous clk edge
   int        sclk_phase = 0;         // clk edges since sclk last changed
   logic      sclk_timed = 1'b0;      // an sclk edge was seen so the next phase can be timed
   logic      start_pending = 1'b0;   // the next byte from the queue opens a case
   int        bit_idx = 0;            // bit of tx_byte to drive next, 0 is the msb
   int        tx_bits_left = 0;       // case bits still to be driven
   int        hold_request = 0;       // hold length of the case in clk cycles
   int        hold_left = 0;          // cycles of hold still to go
   reg_addr_t got_addr[$];            // writes seen by the monitor
   byte_t     got_data[$];
   int        got_errors = 0;         // frame_error pulses seen by the monitor
   longint    budget_ns = 0;          // watchdog limit, set once the vectors are read

   serial_rx_top u_dut (
      .clk         (clk),
      .rst         (rst),
      .serial_in   (serial_in),
      .hold        (hold),
      .sclk        (sclk),
      .wr_valid    (wr_valid),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .frame_error (frame_error),
      .overflow    (overflow)
   );

   always #CLK_HALF clk = ~clk;

   // host side of the serial line plus the hold countdown
   always @(posedge clk) begin
      #1;                                  // inputs change a little after the edge
      sclk_phase = sclk_phase + 1;
      if (sclk != sclk_seen) begin         // sclk changed at this edge
         if (sclk_timed) begin
            check_flag("sclk half period", `BIT_CLK_DIV, sclk_phase);
         end
         sclk_timed = 1'b1;                // the first edge after reset only starts the timing
         sclk_phase = 0;
      end
      if (hold_left > 0) begin
         hold_left = hold_left - 1;
         if (hold_left == 0) begin
            hold = 1'b0;                   // register file is ready again
         end
      end
      if (sclk && !sclk_seen) begin        // sclk rose at this edge
         if (bit_idx == 0) begin
            tx_live = (tx_queue.size() > 0);
            if (tx_live) begin
               tx_byte = tx_queue.pop_front();
               if (start_pending) begin    // the case starts with its first bit
                  start_pending = 1'b0;
                  hold_left     = hold_request;
                  hold          = (hold_request > 0);
               end
            end else begin
               tx_byte = 8'h00;            // idle filler, the parser drops it while hunting
            end
         end
         serial_in = tx_byte[7 - bit_idx]; // msb first
         if (tx_live) begin
            tx_bits_left = tx_bits_left - 1;
         end
         bit_idx = (bit_idx + 1) % 8;
      end
      sclk_seen = sclk;
   end

   // strobes are registered so the falling clk edge sees them settled
   always @(negedge clk) begin
      if (wr_valid) begin
         got_addr.push_back(wr_addr);
         got_data.push_back(wr_data);
      end
      if (frame_error) begin
         got_errors = got_errors + 1;
      end
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "run stopped");
   endtask

   task automatic check_write(input string name, input reg_addr_t exp_addr, input byte_t exp_data,
                              input reg_addr_t act_addr, input byte_t act_data);
      if (act_addr !== exp_addr || act_data !== exp_data) begin
         abort_run($sformatf("[FAIL] %s: expected addr %02h data %02h, got addr %02h data %02h",
                             name, exp_addr, exp_data, act_addr, act_data));
      end
   endtask

   task automatic check_flag(input string name, input int expected, input int actual);
      if (actual !== expected) begin
         abort_run($sformatf("[FAIL] %s: expected %0d, got %0d", name, expected, actual));
      end
   endtask

   function automatic string case_name(input int num);
      case (num)
         1:       return "single_frame";
         2:       return "bad_checksum";
         3:       return "leading_junk";
         4:       return "held_burst";
         5:       return "fifo_overflow";
         default: return $sformatf("case_%0d", num);
      endcase
   endfunction

   // walks the records once to count them and to size the watchdog
   task automatic scan_vectors(output int n_cases, output longint limit_ns);
      int     p;
      int     n_bytes;
      longint cycles;
      p       = 0;
      n_cases = 0;
      cycles  = 0;
      while (p < VEC_WORDS - 3 && vec_mem[p] != 16'h0000) begin
         n_bytes = int'(vec_mem[p + 2]);
         cycles  = cycles + n_bytes * 8 * 2 * `BIT_CLK_DIV + int'(vec_mem[p + 1]);
         p       = p + 3 + n_bytes;
         p       = p + 1 + 2 * int'(vec_mem[p]) + 2;  // writes, error count, overflow
         n_cases = n_cases + 1;
      end
      limit_ns = cycles * CLK_PERIOD * 2;             // double for margin
   endtask

   task automatic run_case(inout int pos);
      int        num;
      int        n_bytes;
      int        n_writes;
      int        n_errors;
      logic      exp_ovf;
      string     name;
      reg_addr_t exp_addr[$];
      byte_t     exp_data[$];
      num     = int'(vec_mem[pos]);
      n_bytes = int'(vec_mem[pos + 2]);
      name    = case_name(num);
      got_addr.delete();
      got_data.delete();
      got_errors   = 0;
      hold_request = int'(vec_mem[pos + 1]);
      tx_bits_left = 8 * n_bytes;
      for (int i = 0; i < n_bytes; i++) begin
         tx_queue.push_back(byte_t'(vec_mem[pos + 3 + i]));
      end
      start_pending = 1'b1;
      pos      = pos + 3 + n_bytes;
      n_writes = int'(vec_mem[pos]);
      for (int i = 0; i < n_writes; i++) begin
         exp_addr.push_back(reg_addr_t'(vec_mem[pos + 1 + 2 * i]));
         exp_data.push_back(byte_t'(vec_mem[pos + 2 + 2 * i]));
      end
      pos      = pos + 1 + 2 * n_writes;
      n_errors = int'(vec_mem[pos]);
      exp_ovf  = vec_mem[pos + 1][0];
      pos      = pos + 2;
      // results first, then the rest of the line and whatever the fifo still holds
      while (got_addr.size() + got_errors < n_writes + n_errors) begin
         @(posedge clk);
      end
      while (tx_bits_left != 0 || hold) begin
         @(posedge clk);
      end
      repeat (DRAIN_CYCLES) @(posedge clk);
      #(CLK_HALF / 2);
      check_flag({name, " write count"}, n_writes, got_addr.size());
      for (int i = 0; i < n_writes; i++) begin
         check_write(name, exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
      end
      check_flag({name, " error count"}, n_errors, got_errors);
      check_flag({name, " overflow"}, int'(exp_ovf), int'(overflow));
   endtask

   initial begin
      wait (budget_ns > 0);
      #(budget_ns);
      abort_run("timeout: the receiver stopped producing results");
   end

   initial begin
      int     pos;
      int     n_cases;
      longint limit_ns;
      rst       = 1'b1;
      serial_in = 1'b0;
      hold      = 1'b0;
      $readmemh("test/serial_rx_vectors.txt", vec_mem);
      scan_vectors(n_cases, limit_ns);
      if (n_cases == 0) begin
         abort_run("the vectors file holds no test cases");
      end
      budget_ns = limit_ns;
      repeat (10) @(posedge clk);
      #1 rst = 1'b0;
      pos = 0;
      for (int c = 0; c < n_cases; c++) begin
         run_case(pos);
      end
      if (u_dut.u_fifo.u_fifo_chk.fail_count + u_dut.u_parser.u_parser_chk.fail_count != 0) begin
         abort_run("an assertion in the fifo or the parser failed");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

/* test/serial_rx_vectors.txt */
// record: test hold_cycles byte_count bytes... write_count (addr data)... error_count overflow
// all words hex, a record of 0000 ends the list
// 1 one good frame
0001 0000 0004 00A5 0012 0034 0026 0001 0012 0034 0000 0000
// 2 checksum off by one bit, gives an error and no write
0002 0000 0004 00A5 0040 000F 004E 0000 0001 0000
// 3 junk before the sync byte is dropped
0003 0000 0007 003C 005A 00FF 00A5 0007 00C3 00C4 0001 0007 00C3 0000 0000
// 4 three frames, hold for 300 cycles which is less than eight byte times
0004 012C 000C
00A5 0001 0011 0010 00A5 0002 0022 0020 00A5 0003 0033 0030
0003 0001 0011 0002 0022 0003 0033 0000 0000
// 5 four frames, hold for 900 cycles so bytes 8 to 13 are dropped
// only the first two frames fit, the tail of frame four is dropped while hunting
0005 0384 0010
00A5 0010 0001 0011 00A5 0020 0002 0022 00A5 0030 0003 0033 00A5 0040 0004 0044
0002 0010 0001 0020 0002 0000 0001
// end of list
0000

/* vlog.f */
+incdir+source
source/serial_rx_pkg.sv
source/spi_byte_deserializer.sv
source/byte_fifo.sv
source/frame_parser.sv
source/serial_rx_top.sv
test/serial_rx_assert.sv
test/serial_rx_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module serial_rx_tb -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
